// File: dv/tb_tut_shell.sv
/*
 * Testbench for the cabinet glue top level
 * Directed tests for controls, DIP capture, video output and PLL retune
 */
`include "tut_defs.svh"

module tb_tut_shell;

	logic                       CLK_49M;
	logic                       rst_n;
	tut_input_pkg::ps2_event_t  ps2_key;
	tut_input_pkg::joy_word_t   joystick_0;
	tut_input_pkg::joy_word_t   joystick_1;
	logic                       ioctl_wr;
	logic [7:0]                 ioctl_index;
	logic [24:0]                ioctl_addr;
	logic [7:0]                 ioctl_dout;
	logic                       orient_horz;
	logic [1:0]                 aspect_mode;
	logic                       underclock;
	logic                       ce_pix;
	logic [4:0]                 r_in;
	logic [4:0]                 g_in;
	logic [4:0]                 b_in;
	logic                       hs;
	logic                       vs;
	logic                       hblank;
	logic                       vblank;
	tut_input_pkg::cabinet_in_t cabinet;
	logic [15:0]                dip_sw;
	logic [7:0]                 vga_r;
	logic [7:0]                 vga_g;
	logic [7:0]                 vga_b;
	logic                       vga_hs;
	logic                       vga_vs;
	logic                       vga_de;
	logic                       ce_pix_out;
	tut_video_pkg::aspect_t     video_arx;
	tut_video_pkg::aspect_t     video_ary;
	logic                       cfg_write;
	tut_video_pkg::mgmt_addr_t  cfg_address;
	tut_video_pkg::mgmt_data_t  cfg_data;
	logic                       cfg_waitrequest;

	// Random back-pressure on the management bus when set
	logic   bp_random;
	integer seed = 99228;
	int     n_value_err = 0;
	int     n_timeout = 0;

	tut_shell uut (.*);

	initial begin
		CLK_49M = 1'b0;
		forever #20 CLK_49M = ~CLK_49M;
	end

	// PLL side answers at the rising edge like the real IP
	always @(posedge CLK_49M) begin
		if (bp_random)
			cfg_waitrequest <= $random(seed);
		else
			cfg_waitrequest <= 1'b0;
	end

	// Hard stop
	initial begin
		repeat (5000) @(posedge CLK_49M);
		$display("Watchdog expired before the test sequence completed");
		$display("Some tests failed");
		$finish;
	end

	// ====================================================================
	// Compare tasks
	// ====================================================================
	task automatic check_cabinet(input string name, input tut_input_pkg::cabinet_in_t exp,
		input tut_input_pkg::cabinet_in_t act);
		if (act !== exp) begin
			n_value_err++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_dip(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			n_value_err++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_rgb(input string name, input tut_video_pkg::rgb8_t exp,
		input tut_video_pkg::rgb8_t act);
		if (act !== exp) begin
			n_value_err++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_aspect(input string name, input tut_video_pkg::aspect_t exp,
		input tut_video_pkg::aspect_t act);
		if (act !== exp) begin
			n_value_err++;
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_mgmt(input tut_video_pkg::mgmt_addr_t exp_addr,
		input tut_video_pkg::mgmt_data_t exp_data, input tut_video_pkg::mgmt_addr_t act_addr,
		input tut_video_pkg::mgmt_data_t act_data);
		if (act_addr !== exp_addr) begin
			n_value_err++;
			$display("[ERROR] %0t cfg_address expected %0d got %0d", $time, exp_addr, act_addr);
		end
		if (act_data !== exp_data) begin
			n_value_err++;
			$display("[ERROR] %0t cfg_data expected %h got %h", $time, exp_data, act_data);
		end
	endtask

	// Single control or sync bit
	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			n_value_err++;
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// ====================================================================
	// Expected values and helpers
	// ====================================================================
	// Nothing pressed, active low fields high
	function automatic tut_input_pkg::cabinet_in_t idle_cabinet();
		tut_input_pkg::cabinet_in_t c;
		c = '0;
		c.coin = '1;
		c.start = '1;
		c.p1_joy = '1;
		c.p2_joy = '1;
		c.p1_fire = 1'b1;
		c.p2_fire = 1'b1;
		c.service = 1'b1;
		return c;
	endfunction

	function automatic logic [7:0] key_code(input int i);
		case (i)
			0: return `TUT_KEY_START1;
			1: return `TUT_KEY_START2;
			2: return `TUT_KEY_COIN1;
			3: return `TUT_KEY_COIN2;
			4: return `TUT_KEY_SERVICE;
			5: return `TUT_KEY_UP;
			6: return `TUT_KEY_DOWN;
			7: return `TUT_KEY_LEFT;
			8: return `TUT_KEY_RIGHT;
			default: return `TUT_KEY_FIRE;
		endcase
	endfunction

	// Cabinet word with only key i held
	function automatic tut_input_pkg::cabinet_in_t key_active(input int i);
		tut_input_pkg::cabinet_in_t c;
		c = idle_cabinet();
		case (i)
			0: c.start[0] = 1'b0;
			1: c.start[1] = 1'b0;
			2: c.coin[0] = 1'b0;
			3: c.coin[1] = 1'b0;
			4: c.service = 1'b0;
			// Joystick nibble index 0 is up, 3 is right
			5: c.p1_joy[0] = 1'b0;
			6: c.p1_joy[1] = 1'b0;
			7: c.p1_joy[2] = 1'b0;
			8: c.p1_joy[3] = 1'b0;
			default: c.p1_fire = 1'b0;
		endcase
		return c;
	endfunction

	// Cabinet word with one gamepad bit set
	function automatic tut_input_pkg::cabinet_in_t pad_active(input int player, input int b);
		tut_input_pkg::cabinet_in_t c;
		c = idle_cabinet();
		// Pad bit 0 is right, which sits at the top of the nibble
		if (b < 4 && player == 0)
			c.p1_joy[3 - b] = 1'b0;
		else if (b < 4)
			c.p2_joy[3 - b] = 1'b0;
		else if (player == 0) begin
			case (b)
				4: c.p1_fire = 1'b0;
				5: c.fire1_r = 1'b1;
				6: c.flash1 = 1'b1;
				7: c.coin[0] = 1'b0;
				8: c.start[0] = 1'b0;
				default: c.start[1] = 1'b0;
			endcase
		end else begin
			case (b)
				4: c.p2_fire = 1'b0;
				5: c.fire2_r = 1'b1;
				default: c.flash2 = 1'b1;
			endcase
		end
		return c;
	endfunction

	// Resistor ladder output for one channel
	function automatic tut_video_pkg::color8_t weight_sum(input tut_video_pkg::color5_t c);
		logic [7:0] w [0:4];
		tut_video_pkg::color8_t total;
		w[0] = `TUT_CW0;
		w[1] = `TUT_CW1;
		w[2] = `TUT_CW2;
		w[3] = `TUT_CW3;
		w[4] = `TUT_CW4;
		total = '0;
		for (int k = 0; k < 5; k++)
			if (c[k])
				total = total + w[k];
		return total;
	endfunction

	// n rising edges, then the next falling edge for sampling
	task automatic settle(input int n);
		repeat (n) @(posedge CLK_49M);
		@(negedge CLK_49M);
	endtask

	// New keyboard event, toggle flipped
	task automatic send_key(input logic [7:0] code, input logic pressed);
		tut_input_pkg::ps2_event_t ev;
		@(posedge CLK_49M);
		ev.toggle = ~ps2_key.toggle;
		ev.pressed = pressed;
		ev.extended = 1'b0;
		ev.code = code;
		ps2_key <= ev;
	endtask

	// One byte on the download stream, sampled one cycle later
	task automatic dl_write(input logic [7:0] idx, input logic [24:0] a, input logic [7:0] d);
		@(posedge CLK_49M);
		ioctl_wr <= 1'b1;
		ioctl_index <= idx;
		ioctl_addr <= a;
		ioctl_dout <= d;
		@(posedge CLK_49M);
		ioctl_wr <= 1'b0;
		@(negedge CLK_49M);
	endtask

	// cfg_write must stay low for n cycles
	task automatic expect_no_writes(input int n);
		int i;
		i = 0;
		while (i < n && !cfg_write) begin
			@(negedge CLK_49M);
			i++;
		end
		check_bit("cfg_write", 1'b0, cfg_write);
	endtask

	// Switch the speed bit and collect the three accepted writes
	task automatic run_retune(input logic slow, input tut_video_pkg::mgmt_data_t word);
		tut_video_pkg::mgmt_addr_t exp_addr [0:2];
		tut_video_pkg::mgmt_data_t exp_data [0:2];
		int taken;
		int waited;
		exp_addr[0] = `TUT_PLL_ADDR_MODE;
		exp_addr[1] = `TUT_PLL_ADDR_M;
		exp_addr[2] = `TUT_PLL_ADDR_START;
		exp_data[0] = '0;
		exp_data[1] = word;
		exp_data[2] = '0;
		@(posedge CLK_49M);
		underclock <= slow;
		taken = 0;
		waited = 0;
		while (taken < 3 && waited < 300) begin
			@(negedge CLK_49M);
			waited++;
			// Taken at the coming edge
			if (cfg_write && !cfg_waitrequest) begin
				check_mgmt(exp_addr[taken], exp_data[taken], cfg_address, cfg_data);
				taken++;
			end
		end
		if (taken < 3) begin
			n_timeout++;
			$display("Timed out waiting for PLL write %0d of 3", taken + 1);
		end else begin
			settle(1);
			expect_no_writes(40);
		end
	endtask

	// ====================================================================
	// Directed tests
	// ====================================================================
	task automatic test_reset_values();
		tut_video_pkg::rgb8_t act;
		@(negedge CLK_49M);
		act = {vga_r, vga_g, vga_b};
		check_cabinet("cabinet", idle_cabinet(), cabinet);
		check_dip("dip_sw", 16'h0000, dip_sw);
		check_bit("cfg_write", 1'b0, cfg_write);
		check_rgb("vga_rgb", '0, act);
		check_bit("vga_hs", 1'b0, vga_hs);
		check_bit("vga_vs", 1'b0, vga_vs);
		check_bit("vga_de", 1'b0, vga_de);
		check_bit("ce_pix_out", 1'b0, ce_pix_out);
	endtask

	task automatic test_keyboard();
		for (int i = 0; i < 10; i++) begin
			send_key(key_code(i), 1'b1);
			// Still idle one cycle in
			settle(1);
			check_cabinet("cabinet", idle_cabinet(), cabinet);
			settle(1);
			check_cabinet("cabinet", key_active(i), cabinet);
			send_key(key_code(i), 1'b0);
			settle(2);
			check_cabinet("cabinet", idle_cabinet(), cabinet);
		end
		// Unmapped key
		send_key(8'h1C, 1'b1);
		settle(2);
		check_cabinet("cabinet", idle_cabinet(), cabinet);
	endtask

	task automatic test_gamepad();
		for (int b = 0; b < 10; b++) begin
			@(posedge CLK_49M);
			joystick_0 <= 16'h0001 << b;
			settle(1);
			check_cabinet("cabinet", pad_active(0, b), cabinet);
			@(posedge CLK_49M);
			joystick_0 <= '0;
			settle(1);
			check_cabinet("cabinet", idle_cabinet(), cabinet);
		end
		for (int b = 0; b < 7; b++) begin
			@(posedge CLK_49M);
			joystick_1 <= 16'h0001 << b;
			settle(1);
			check_cabinet("cabinet", pad_active(1, b), cabinet);
			@(posedge CLK_49M);
			joystick_1 <= '0;
			settle(1);
			check_cabinet("cabinet", idle_cabinet(), cabinet);
		end
	endtask

	// Key and pad on the same control, pad released first
	task automatic test_key_pad_or();
		send_key(`TUT_KEY_UP, 1'b1);
		@(posedge CLK_49M);
		// Pad bit 3 is up
		joystick_0 <= 16'h0008;
		settle(2);
		check_cabinet("cabinet", key_active(5), cabinet);
		@(posedge CLK_49M);
		joystick_0 <= '0;
		settle(1);
		check_cabinet("cabinet", key_active(5), cabinet);
		send_key(`TUT_KEY_UP, 1'b0);
		settle(2);
		check_cabinet("cabinet", idle_cabinet(), cabinet);
	endtask

	task automatic test_dip();
		logic [7:0] b0;
		logic [7:0] b1;
		b0 = $random(seed);
		b1 = $random(seed);
		dl_write(`TUT_DIP_INDEX, 25'd0, b0);
		check_dip("dip_sw", ~{8'hFF, b0}, dip_sw);
		dl_write(`TUT_DIP_INDEX, 25'd1, b1);
		check_dip("dip_sw", ~{b1, b0}, dip_sw);
		// Wrong index, then an address past the two bytes, data always differs
		dl_write(8'd253, 25'd0, ~b0);
		check_dip("dip_sw", ~{b1, b0}, dip_sw);
		dl_write(`TUT_DIP_INDEX, 25'd5, ~b1);
		check_dip("dip_sw", ~{b1, b0}, dip_sw);
	endtask

	task automatic test_colour();
		tut_video_pkg::rgb8_t exp;
		tut_video_pkg::rgb8_t act;
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
		logic [3:0] sync;
		repeat (20) begin
			r = $random(seed);
			g = $random(seed);
			b = $random(seed);
			sync = $random(seed);
			@(posedge CLK_49M);
			ce_pix <= 1'b1;
			r_in <= r;
			g_in <= g;
			b_in <= b;
			{hs, vs, hblank, vblank} <= sync;
			settle(1);
			exp.r = weight_sum(r);
			exp.g = weight_sum(g);
			exp.b = weight_sum(b);
			act = {vga_r, vga_g, vga_b};
			check_rgb("vga_rgb", exp, act);
			check_bit("vga_hs", sync[3], vga_hs);
			check_bit("vga_vs", sync[2], vga_vs);
			check_bit("vga_de", ~(sync[1] | sync[0]), vga_de);
			check_bit("ce_pix_out", 1'b1, ce_pix_out);
		end
		@(posedge CLK_49M);
		ce_pix <= 1'b0;
		settle(1);
		check_bit("ce_pix_out", 1'b0, ce_pix_out);
	endtask

	task automatic test_aspect();
		tut_video_pkg::aspect_t ex;
		tut_video_pkg::aspect_t ey;
		for (int m = 0; m < 4; m++) begin
			for (int h = 0; h < 2; h++) begin
				@(posedge CLK_49M);
				aspect_mode <= m;
				orient_horz <= h;
				settle(0);
				if (m == 0) begin
					ex = h ? 13'd16 : 13'd14;
					ey = h ? 13'd14 : 13'd16;
				end else begin
					ex = m - 1;
					ey = 13'd0;
				end
				check_aspect("video_arx", ex, video_arx);
				check_aspect("video_ary", ey, video_ary);
			end
		end
	endtask

	task automatic test_pll();
		bp_random = 1'b1;
		run_retune(1'b1, `TUT_PLL_M_SLOW);
		run_retune(1'b0, `TUT_PLL_M_NATIVE);
		// Speed bit left alone
		expect_no_writes(60);
		bp_random = 1'b0;
	endtask

	// ====================================================================
	// Sequence
	// ====================================================================
	initial begin
		rst_n = 1'b0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		orient_horz = 1'b0;
		aspect_mode = 2'd0;
		underclock = 1'b0;
		ce_pix = 1'b0;
		r_in = '0;
		g_in = '0;
		b_in = '0;
		hs = 1'b0;
		vs = 1'b0;
		hblank = 1'b0;
		vblank = 1'b0;
		cfg_waitrequest = 1'b0;
		bp_random = 1'b0;
		repeat (5) @(posedge CLK_49M);
		rst_n <= 1'b1;
		test_reset_values();
		test_keyboard();
		test_gamepad();
		test_key_pad_or();
		test_dip();
		test_colour();
		test_aspect();
		test_pll();
		$display("Value errors: %0d, timeouts: %0d", n_value_err, n_timeout);
		if (n_value_err == 0 && n_timeout == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: tut_shell.f
+incdir+verilog
verilog/tut_input_pkg.sv
verilog/tut_video_pkg.sv
verilog/download_if.sv
verilog/ps2_key_decoder.sv
verilog/cabinet_inputs.sv
verilog/dip_loader.sv
verilog/video_out.sv
verilog/pll_reconfig.sv
verilog/tut_shell.sv
dv/tb_tut_shell.sv

// File: verilog/cabinet_inputs.sv
/*
 * Cabinet input merge
 * Keyboard and gamepads combined into the registered control word
 */
module cabinet_inputs (
	input  logic                       CLK_49M,
	input  logic                       rst_n,
	input  tut_input_pkg::ps2_event_t  ps2_key,
	input  tut_input_pkg::joy_word_t   joystick_0,
	input  tut_input_pkg::joy_word_t   joystick_1,
	output tut_input_pkg::cabinet_in_t cabinet
);

	// All controls released
	localparam tut_input_pkg::cabinet_in_t CAB_IDLE = '{
		coin: 2'b11, start: 2'b11, p1_joy: 4'hF, p2_joy: 4'hF,
		p1_fire: 1'b1, p2_fire: 1'b1, service: 1'b1,
		fire1_r: 1'b0, flash1: 1'b0, fire2_r: 1'b0, flash2: 1'b0
	};

	tut_input_pkg::key_state_t  keys;
	tut_input_pkg::cabinet_in_t cab_next;

	ps2_key_decoder u_keys (
		.CLK_49M (CLK_49M),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	// ==================================================================
	// Merge, pad bits 3..0 are up, down, left, right
	// ==================================================================
	always_comb begin
		cab_next.coin    = ~{keys.coin2, keys.coin1 | joystick_0[7]};
		cab_next.start   = ~{keys.start2 | joystick_0[9], keys.start1 | joystick_0[8]};
		// Nibble order right, left, down, up
		cab_next.p1_joy  = ~{keys.right | joystick_0[0], keys.left | joystick_0[1],
			keys.down | joystick_0[2], keys.up | joystick_0[3]};
		// Second player has no keyboard mapping
		cab_next.p2_joy  = ~{joystick_1[0], joystick_1[1], joystick_1[2], joystick_1[3]};
		cab_next.p1_fire = ~(keys.fire | joystick_0[4]);
		cab_next.p2_fire = ~joystick_1[4];
		cab_next.service = ~keys.service;
		cab_next.fire1_r = joystick_0[5];
		cab_next.flash1  = joystick_0[6];
		cab_next.fire2_r = joystick_1[5];
		cab_next.flash2  = joystick_1[6];
	end

	always_ff @(posedge CLK_49M) begin
		if (!rst_n)
			cabinet <= CAB_IDLE;
		else
			cabinet <= cab_next;
	end

	// Keyboard-only controls still released in the first cycle out of reset
	a_idle_after_reset: assert property (
		@(posedge CLK_49M) $rose(rst_n) |=> (cabinet.coin[1] && cabinet.service)
	);

endmodule

// File: verilog/dip_loader.sv
/*
 * DIP switch capture
 * Takes bytes 0 and 1 of the DIP download into active-low storage
 */
`include "tut_defs.svh"

module dip_loader (
	input  logic          CLK_49M,
	input  logic          rst_n,
	download_if.sink      dl,
	output logic [15:0]   dip_sw
);

	// Stored as downloaded, active low
	logic [7:0] dip_b0;
	logic [7:0] dip_b1;
	logic       dip_hit;

	// Only the first two addresses of the DIP index
	assign dip_hit = dl.wr && (dl.index == `TUT_DIP_INDEX) && (dl.addr[24:1] == '0);

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			// All switches off
			dip_b0 <= 8'hFF;
			dip_b1 <= 8'hFF;
		end else if (dip_hit) begin
			if (dl.addr[0])
				dip_b1 <= dl.data;
			else
				dip_b0 <= dl.data;
		end
	end

	// Game expects active high, byte 1 on top
	assign dip_sw = ~{dip_b1, dip_b0};

endmodule

// File: verilog/download_if.sv
/*
 * Download stream bundle
 * One byte per cycle with wr high, no back-pressure
 */
interface download_if;

	logic        wr;
	logic [7:0]  index;
	logic [24:0] addr;
	logic [7:0]  data;

	// Consumer side
	modport sink (
		input wr,
		input index,
		input addr,
		input data
	);

endinterface

// File: verilog/pll_reconfig.sv
/*
 * Video PLL retune
 * Follows the 60 Hz speed switch and writes the new counter through the
 * management bus in three held writes
 */
`include "tut_defs.svh"

module pll_reconfig (
	input  logic                      CLK_49M,
	input  logic                      rst_n,
	input  logic                      underclock,
	output logic                      cfg_write,
	output tut_video_pkg::mgmt_addr_t cfg_address,
	output tut_video_pkg::mgmt_data_t cfg_data,
	input  logic                      cfg_waitrequest
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MODE,
		ST_M,
		ST_START
	} state_t;

	state_t state;
	// Two flop synchroniser on the switch
	logic   uc_s1;
	logic   uc_s2;
	// Mode currently programmed, 1 for slowed
	logic   mode_q;
	logic   accepted;
	logic   kick;

	assign accepted = cfg_write && !cfg_waitrequest;
	// Settled new value while no sequence is running
	assign kick = (state == ST_IDLE) && (uc_s2 == uc_s1) && (uc_s2 != mode_q);

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			uc_s1  <= 1'b0;
			uc_s2  <= 1'b0;
			mode_q <= 1'b0;
			state  <= ST_IDLE;
			cfg_write <= 1'b0;
		end else begin
			uc_s1 <= underclock;
			uc_s2 <= uc_s1;
			case (state)
				ST_IDLE: begin
					if (kick) begin
						mode_q      <= uc_s2;
						cfg_write   <= 1'b1;
						cfg_address <= `TUT_PLL_ADDR_MODE;
						cfg_data    <= '0;
						state       <= ST_MODE;
					end
				end
				ST_MODE: begin
					if (accepted) begin
						cfg_address <= `TUT_PLL_ADDR_M;
						cfg_data    <= mode_q ? `TUT_PLL_M_SLOW : `TUT_PLL_M_NATIVE;
						state       <= ST_M;
					end
				end
				ST_M: begin
					if (accepted) begin
						cfg_address <= `TUT_PLL_ADDR_START;
						cfg_data    <= '0;
						state       <= ST_START;
					end
				end
				// Last write, drop the request once taken
				ST_START: begin
					if (accepted) begin
						cfg_write <= 1'b0;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ==================================================================
	// Management bus rules
	// ==================================================================
	a_hold_stalled: assert property (
		@(posedge CLK_49M) disable iff (!rst_n)
		(cfg_write && cfg_waitrequest) |=>
			(cfg_write && $stable(cfg_address) && $stable(cfg_data))
	);

	// Synchroniser keeps the bus quiet for two cycles out of reset
	a_quiet_after_reset: assert property (
		@(posedge CLK_49M) $rose(rst_n) |=> (!cfg_write) [*2]
	);

endmodule

// File: verilog/ps2_key_decoder.sv
/*
 * Keyboard event decoder
 * Detects each new event and keeps a held flag per mapped button
 */
`include "tut_defs.svh"

module ps2_key_decoder (
	input  logic                    CLK_49M,
	input  logic                    rst_n,
	input  tut_input_pkg::ps2_event_t ps2_key,
	output tut_input_pkg::key_state_t keys
);

	// Last seen toggle bit
	logic toggle_q;
	logic new_event;

	// A new event is any flip of the toggle
	assign new_event = (ps2_key.toggle != toggle_q);

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
			keys     <= '0;
		end else begin
			toggle_q <= ps2_key.toggle;
			if (new_event) begin
				// Press sets, release clears
				case (ps2_key.code)
					`TUT_KEY_START1:  keys.start1  <= ps2_key.pressed;
					`TUT_KEY_START2:  keys.start2  <= ps2_key.pressed;
					`TUT_KEY_COIN1:   keys.coin1   <= ps2_key.pressed;
					`TUT_KEY_COIN2:   keys.coin2   <= ps2_key.pressed;
					`TUT_KEY_SERVICE: keys.service <= ps2_key.pressed;
					`TUT_KEY_UP:      keys.up      <= ps2_key.pressed;
					`TUT_KEY_DOWN:    keys.down    <= ps2_key.pressed;
					`TUT_KEY_LEFT:    keys.left    <= ps2_key.pressed;
					`TUT_KEY_RIGHT:   keys.right   <= ps2_key.pressed;
					`TUT_KEY_FIRE:    keys.fire    <= ps2_key.pressed;
					// Unmapped codes leave the state alone
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/tut_defs.svh
/*
 * Shared constants for the cabinet glue
 * Keyboard scan codes, resistor weights, PLL retune words and download index
 */
`ifndef TUT_DEFS_SVH
`define TUT_DEFS_SVH

// ======================================================================
// Keyboard scan codes (set 2, make codes)
// ======================================================================
`define TUT_KEY_START1   8'h16
`define TUT_KEY_START2   8'h1E
`define TUT_KEY_COIN1    8'h2E
`define TUT_KEY_COIN2    8'h36
`define TUT_KEY_SERVICE  8'h46
// Arrows share their code with the keypad, extended flag not needed
`define TUT_KEY_UP       8'h75
`define TUT_KEY_DOWN     8'h72
`define TUT_KEY_LEFT     8'h6B
`define TUT_KEY_RIGHT    8'h74
// Left ctrl
`define TUT_KEY_FIRE     8'h14

// ======================================================================
// Colour DAC weights, one per bit of a 5-bit channel
// ======================================================================
`define TUT_CW0  8'h19
`define TUT_CW1  8'h24
`define TUT_CW2  8'h35
`define TUT_CW3  8'h40
// Full scale sums to 8'hFF
`define TUT_CW4  8'h4D

// ======================================================================
// Video PLL management words
// ======================================================================
`define TUT_PLL_M_NATIVE   32'd3639383488
`define TUT_PLL_M_SLOW     32'd3268298314
`define TUT_PLL_ADDR_MODE  6'd0
`define TUT_PLL_ADDR_M     6'd7
`define TUT_PLL_ADDR_START 6'd2

// Download stream index that carries the DIP bytes
`define TUT_DIP_INDEX  8'd254

`endif

// File: verilog/tut_input_pkg.sv
/*
 * Control-side types
 * Keyboard event, held-key state and the cabinet input word
 */
package tut_input_pkg;

	// One keyboard event as delivered by the host, 11 bits
	typedef struct packed {
		// Flips on every new event
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_event_t;

	// Held flag per keyboard button
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic service;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} key_state_t;

	// Game control inputs
	// Joystick nibbles are ordered right, left, down, up
	typedef struct packed {
		// Active low group
		logic [1:0] coin;
		logic [1:0] start;
		logic [3:0] p1_joy;
		logic [3:0] p2_joy;
		logic       p1_fire;
		logic       p2_fire;
		logic       service;
		// Active high group
		logic       fire1_r;
		logic       flash1;
		logic       fire2_r;
		logic       flash2;
	} cabinet_in_t;

	// Gamepad button word from the host
	typedef logic [15:0] joy_word_t;

endpackage

// File: verilog/tut_shell.sv
/*
 * Cabinet glue top level
 * Input merge, DIP capture, video output and PLL retune on one clock
 */
module tut_shell (
	input  logic                       CLK_49M,
	input  logic                       rst_n,
	// Host controls
	input  logic [10:0]                ps2_key,
	input  logic [15:0]                joystick_0,
	input  logic [15:0]                joystick_1,
	// Download stream
	input  logic                       ioctl_wr,
	input  logic [7:0]                 ioctl_index,
	input  logic [24:0]                ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	// Menu options
	input  logic                       orient_horz,
	input  logic [1:0]                 aspect_mode,
	input  logic                       underclock,
	// Game video
	input  logic                       ce_pix,
	input  logic [4:0]                 r_in,
	input  logic [4:0]                 g_in,
	input  logic [4:0]                 b_in,
	input  logic                       hs,
	input  logic                       vs,
	input  logic                       hblank,
	input  logic                       vblank,
	// To the game
	output tut_input_pkg::cabinet_in_t cabinet,
	output logic [15:0]                dip_sw,
	// To the scaler
	output logic [7:0]                 vga_r,
	output logic [7:0]                 vga_g,
	output logic [7:0]                 vga_b,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       vga_de,
	output logic                       ce_pix_out,
	output logic [12:0]                video_arx,
	output logic [12:0]                video_ary,
	// PLL management bus
	output logic                       cfg_write,
	output logic [5:0]                 cfg_address,
	output logic [31:0]                cfg_data,
	input  logic                       cfg_waitrequest
);

	download_if dl_bus ();

	assign dl_bus.wr    = ioctl_wr;
	assign dl_bus.index = ioctl_index;
	assign dl_bus.addr  = ioctl_addr;
	assign dl_bus.data  = ioctl_dout;

	cabinet_inputs u_inputs (
		.CLK_49M    (CLK_49M),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.cabinet    (cabinet)
	);

	dip_loader u_dip (
		.CLK_49M (CLK_49M),
		.rst_n   (rst_n),
		.dl      (dl_bus),
		.dip_sw  (dip_sw)
	);

	// Channels packed r, g, b from the top
	video_out u_video (
		.CLK_49M     (CLK_49M),
		.rst_n       (rst_n),
		.ce_pix      (ce_pix),
		.rgb_in      ({r_in, g_in, b_in}),
		.hs          (hs),
		.vs          (vs),
		.hblank      (hblank),
		.vblank      (vblank),
		.orient_horz (orient_horz),
		.aspect_mode (aspect_mode),
		.vga_rgb     ({vga_r, vga_g, vga_b}),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_de      (vga_de),
		.ce_pix_out  (ce_pix_out),
		.video_arx   (video_arx),
		.video_ary   (video_ary)
	);

	pll_reconfig u_pll (
		.CLK_49M         (CLK_49M),
		.rst_n           (rst_n),
		.underclock      (underclock),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data),
		.cfg_waitrequest (cfg_waitrequest)
	);

endmodule

// File: verilog/tut_video_pkg.sv
/*
 * Video and PLL management types
 * Colour channels, RGB triples, aspect values and the management bus words
 */
package tut_video_pkg;

	// Game side colour channel
	typedef logic [4:0] color5_t;

	// Output colour channel
	typedef logic [7:0] color8_t;

	typedef struct packed {
		color5_t r;
		color5_t g;
		color5_t b;
	} rgb5_t;

	typedef struct packed {
		color8_t r;
		color8_t g;
		color8_t b;
	} rgb8_t;

	// Aspect ratio term for the scaler
	typedef logic [12:0] aspect_t;

	// PLL reconfiguration bus
	typedef logic [5:0]  mgmt_addr_t;
	typedef logic [31:0] mgmt_data_t;

endpackage

// File: verilog/video_out.sv
/*
 * Video output stage
 * Resistor-weighted colour expansion, sync alignment and aspect choice
 */
`include "tut_defs.svh"

module video_out (
	input  logic                   CLK_49M,
	input  logic                   rst_n,
	input  logic                   ce_pix,
	input  tut_video_pkg::rgb5_t   rgb_in,
	input  logic                   hs,
	input  logic                   vs,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   orient_horz,
	input  logic [1:0]             aspect_mode,
	output tut_video_pkg::rgb8_t   vga_rgb,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   vga_de,
	output logic                   ce_pix_out,
	output tut_video_pkg::aspect_t video_arx,
	output tut_video_pkg::aspect_t video_ary
);

	// Sum of the weights of the set bits
	function automatic tut_video_pkg::color8_t weigh5(input tut_video_pkg::color5_t c);
		tut_video_pkg::color8_t acc;
		acc = 8'h00;
		if (c[0]) acc = acc + `TUT_CW0;
		if (c[1]) acc = acc + `TUT_CW1;
		if (c[2]) acc = acc + `TUT_CW2;
		if (c[3]) acc = acc + `TUT_CW3;
		if (c[4]) acc = acc + `TUT_CW4;
		return acc;
	endfunction

	// ==================================================================
	// One register stage, colour and timing stay aligned
	// ==================================================================
	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			vga_rgb    <= '0;
			vga_hs     <= 1'b0;
			vga_vs     <= 1'b0;
			vga_de     <= 1'b0;
			ce_pix_out <= 1'b0;
		end else begin
			vga_rgb.r  <= weigh5(rgb_in.r);
			vga_rgb.g  <= weigh5(rgb_in.g);
			vga_rgb.b  <= weigh5(rgb_in.b);
			vga_hs     <= hs;
			vga_vs     <= vs;
			vga_de     <= ~(hblank | vblank);
			ce_pix_out <= ce_pix;
		end
	end

	// Mode 0 is the native monitor shape, others are scaler presets
	always_comb begin
		if (aspect_mode == 2'd0) begin
			video_arx = orient_horz ? 13'd16 : 13'd14;
			video_ary = orient_horz ? 13'd14 : 13'd16;
		end else begin
			video_arx = {11'd0, aspect_mode} - 13'd1;
			video_ary = 13'd0;
		end
	end

endmodule
